// File: hw/lsab_pkg.sv
`default_nettype none

package lsab_pkg;

  // word addressing, split into page and in-page offset
  localparam int ADDR_W    = 32;
  localparam int PAGE_BITS = 12;
  localparam int PAGE_W    = ADDR_W - PAGE_BITS; // 20 bit page address

  // block and transfer sizing
  localparam int BLOCK_LEN = 24;
  localparam int CNT_W     = 5;
  localparam int LEN_W     = 16;
  localparam int SECT_W    = 2;

  // output stream credits
  localparam int OUT_CREDITS = 4;
  localparam int CRED_W      = $clog2(OUT_CREDITS + 1);

  typedef enum logic [2:0] {
    IDLE,  // waiting for a request
    SIZE,  // counter works out the block
    ALIGN, // page open request to the MCU
    ISSUE, // block handed to the mover
    WAIT,  // mover busy
    NEXT   // advance address, decide on next block
  } xfer_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SECT_W-1:0] section;
    logic [LEN_W-1:0]  length;
  } xfer_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] start;
    logic [CNT_W-1:0]  count;
    logic [SECT_W-1:0] section;
  } blk_cmd_t;

  // one word descriptor on the output stream
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [SECT_W-1:0] section;
    logic              last_of_block;
    logic              last_of_xfer;
  } dram_word_t;

endpackage

`default_nettype wire

// File: hw/xfer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_sequencer
  import lsab_pkg::*;
(
  input  wire logic CLK,
  input  wire logic RST,
  // transfer request handshake
  input  wire logic req_valid,
  output logic      req_ready,
  // memory control unit
  output logic      mcu_req,
  input  wire logic mcu_grant,
  // counter
  input  wire logic last_blk,
  output logic      load,
  output logic      advance,
  // block mover
  output logic      issue,
  input  wire logic mover_done,
  output logic      xfer_done
);

  xfer_state_e state;
  xfer_state_e state_nxt;
  logic        grant_seen;

  // grant only counts once our request is actually up
  assign grant_seen = (state == ALIGN) && mcu_req && mcu_grant;

  assign req_ready = (state == IDLE);
  assign load      = req_valid && req_ready; // counter captures req on this edge
  assign advance   = (state == NEXT);
  assign xfer_done = (state == NEXT) && last_blk;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (req_valid)
          state_nxt = SIZE;
      end
      SIZE:
      begin
        state_nxt = ALIGN; // blk_cmd registered on this edge
      end
      ALIGN:
      begin
        if (grant_seen)
          state_nxt = ISSUE;
      end
      ISSUE:
      begin
        state_nxt = WAIT;
      end
      WAIT:
      begin
        if (mover_done)
          state_nxt = NEXT;
      end
      NEXT:
      begin
        if (last_blk)
          state_nxt = IDLE;
        else
          state_nxt = SIZE;
      end
      default:
      begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  // page request held from ALIGN until the mover reports the block done
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      mcu_req <= 1'b0;
    end
    else if (state == ALIGN)
    begin
      mcu_req <= 1'b1;
    end
    else if ((state == WAIT) && mover_done)
    begin
      mcu_req <= 1'b0;
    end
  end

  // one cycle issue pulse, mover latches the block on the following edge
  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      issue <= 1'b0;
    end
    else
    begin
      issue <= grant_seen;
    end
  end

endmodule

`default_nettype wire

// File: hw/xfer_counter.sv
`timescale 1ns/1ps
`default_nettype none

module xfer_counter
  import lsab_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire xfer_req_t        req,
  input  wire logic             load,
  input  wire logic             advance,
  input  wire logic [CNT_W-1:0] sent_count,
  output blk_cmd_t              blk_cmd,
  output logic [PAGE_W-1:0]     mcu_page_addr,
  output logic                  last_blk
);

  logic [ADDR_W-1:0]    cur_addr;
  logic [LEN_W-1:0]     remain;
  logic [SECT_W-1:0]    section;
  logic                 pending;   // size the block on the next edge
  logic [PAGE_BITS-1:0] offset;
  logic [PAGE_BITS:0]   end_addr;  // top bit is the page carry
  logic [CNT_W-1:0]     page_left;
  logic [CNT_W-1:0]     page_cnt;
  logic [CNT_W-1:0]     blk_count;

  assign offset   = cur_addr[PAGE_BITS-1:0];
  assign end_addr = {1'b0, offset} + (PAGE_BITS + 1)'(BLOCK_LEN);

  // words up to the page end, only small enough to matter when end_addr carries
  assign page_left = ~offset[CNT_W-1:0] + 1'b1;
  assign page_cnt  = end_addr[PAGE_BITS] ? page_left : CNT_W'(BLOCK_LEN);

  // tail of the transfer may be shorter still
  assign blk_count = (remain < LEN_W'(page_cnt)) ? remain[CNT_W-1:0] : page_cnt;

  assign mcu_page_addr = blk_cmd.start[ADDR_W-1:PAGE_BITS];
  assign last_blk      = (remain == LEN_W'(blk_cmd.count));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      pending <= 1'b0;
    end
    else
    begin
      pending <= load || advance;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (load)
    begin
      cur_addr <= req.addr;
      remain   <= req.length;
      section  <= req.section;
    end
    else if (advance)
    begin
      cur_addr <= cur_addr + ADDR_W'(sent_count);
      remain   <= remain - LEN_W'(sent_count);
    end

    if (pending)
    begin
      blk_cmd.start   <= cur_addr;
      blk_cmd.count   <= blk_count;
      blk_cmd.section <= section;
    end
  end

endmodule

`default_nettype wire

// File: hw/block_mover.sv
`timescale 1ns/1ps
`default_nettype none

module block_mover
  import lsab_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             RST,
  input  wire blk_cmd_t         cmd,
  input  wire logic             issue,
  output logic                  busy,
  output logic                  done,
  output logic [CNT_W-1:0]      sent_count,
  input  wire logic             last_xfer,
  // output stream
  input  wire logic             credit_ret,
  output logic                  word_valid,
  output dram_word_t            word
);

  logic [ADDR_W-1:0] cur_addr;
  logic [SECT_W-1:0] section;
  logic [CNT_W-1:0]  left;      // words still to send
  logic              last_x;    // block closes the transfer
  logic [CRED_W-1:0] credits;
  logic [CRED_W:0]   credit_sum;
  logic              have_credit;
  logic              fire;

  // a credit returned this cycle can be spent straight away
  assign have_credit = (credits != '0) || credit_ret;
  assign fire        = busy && have_credit;

  assign word_valid         = fire;
  assign word.addr          = cur_addr;
  assign word.section       = section;
  assign word.last_of_block = (left == CNT_W'(1));
  assign word.last_of_xfer  = (left == CNT_W'(1)) && last_x;

  assign credit_sum = {1'b0, credits} + CRED_W'(credit_ret) - CRED_W'(fire);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      credits <= CRED_W'(OUT_CREDITS);
    end
    else if (credit_sum > (CRED_W + 1)'(OUT_CREDITS))
    begin
      credits <= CRED_W'(OUT_CREDITS); // stray return, hold at the ceiling
    end
    else
    begin
      credits <= credit_sum[CRED_W-1:0];
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      busy       <= 1'b0;
      done       <= 1'b0;
      left       <= '0;
      sent_count <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (issue && !busy)
      begin
        busy       <= 1'b1;
        left       <= cmd.count;
        sent_count <= '0;
      end
      else if (fire)
      begin
        left       <= left - 1'b1;
        sent_count <= sent_count + 1'b1;
        if (left == CNT_W'(1))
        begin
          busy <= 1'b0;
          done <= 1'b1; // cycle after the final word
        end
      end
    end
  end

  // address and tags of the block in flight
  always_ff @(posedge CLK)
  begin
    if (issue && !busy)
    begin
      cur_addr <= cmd.start;
      section  <= cmd.section;
      last_x   <= last_xfer;
    end
    else if (fire)
    begin
      cur_addr <= cur_addr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/dram_xfer_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dram_xfer_engine
  import lsab_pkg::*;
(
  input  wire logic          CLK,
  input  wire logic          RST,
  // transfer request
  input  wire logic          req_valid,
  input  wire xfer_req_t     req,
  output logic               req_ready,
  // memory control unit
  output logic               mcu_req,
  output logic [PAGE_W-1:0]  mcu_page_addr,
  input  wire logic          mcu_grant,
  // word stream, credit based
  output logic               word_valid,
  output dram_word_t         word,
  input  wire logic          credit_ret,
  output logic               xfer_done
);

  logic             load;
  logic             advance;
  logic             issue;
  logic             last_blk;
  logic             mover_done;
  logic [CNT_W-1:0] sent_count;
  blk_cmd_t         blk_cmd;

  xfer_sequencer i_sequencer (
    .CLK        (CLK),
    .RST        (RST),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .mcu_req    (mcu_req),
    .mcu_grant  (mcu_grant),
    .last_blk   (last_blk),
    .load       (load),
    .advance    (advance),
    .issue      (issue),
    .mover_done (mover_done),
    .xfer_done  (xfer_done)
  );

  xfer_counter i_counter (
    .CLK           (CLK),
    .RST           (RST),
    .req           (req),
    .load          (load),
    .advance       (advance),
    .sent_count    (sent_count),
    .blk_cmd       (blk_cmd),
    .mcu_page_addr (mcu_page_addr),
    .last_blk      (last_blk)
  );

  // busy stays internal, the sequencer follows the done pulse
  block_mover i_mover (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (blk_cmd),
    .issue      (issue),
    .busy       (),
    .done       (mover_done),
    .sent_count (sent_count),
    .last_xfer  (last_blk),
    .credit_ret (credit_ret),
    .word_valid (word_valid),
    .word       (word)
  );

endmodule

`default_nettype wire

// File: verif/tb_dram_xfer_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dram_xfer_engine
  import lsab_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int SEED         = 49098;
  // transfer lengths of the directed tests
  localparam int LEN_SHORT = 10;
  localparam int LEN_MULTI = 100;
  localparam int LEN_CROSS = 40;
  localparam int LEN_BP    = 60;
  localparam int LEN_SLOW  = 30;
  localparam int TOTAL_WORDS = LEN_SHORT + LEN_MULTI + LEN_CROSS + LEN_BP + LEN_SLOW;
  localparam int MAX_GAP        = 6;  // credit return gap under back-pressure
  localparam int SLOW_GRANT_MIN = 5;
  localparam int SLOW_GRANT_MAX = 12;
  localparam int MAX_BLOCKS     = TOTAL_WORDS / BLOCK_LEN + 2 * 5;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_WORDS * (MAX_GAP + 2)
                                   + MAX_BLOCKS * (SLOW_GRANT_MAX + 12) + 200;

  logic              CLK;
  logic              RST;
  logic              req_valid;
  xfer_req_t         req;
  logic              req_ready;
  logic              mcu_req;
  logic [PAGE_W-1:0] mcu_page_addr;
  logic              mcu_grant;
  logic              word_valid;
  dram_word_t        word;
  logic              credit_ret;
  logic              xfer_done;

  // reference lists and what the monitor saw
  dram_word_t        exp_q[$];
  int                exp_blk_q[$];
  logic [PAGE_W-1:0] exp_page_q[$];
  dram_word_t        got_q[$];
  logic [PAGE_W-1:0] got_page_q[$];

  string             cur_test;
  int                errors;
  int                err_base;
  int                tests_run;
  int                tests_failed;
  int                done_count;
  int                stall_cycles; // mcu_req up, grant still low
  int                outstanding;  // words not yet credited back
  int                gap_max;
  int                grant_min;
  int                grant_max;
  logic              mcu_req_q;
  logic [PAGE_W-1:0] page_q;

  dram_xfer_engine i_dut (
    .CLK           (CLK),
    .RST           (RST),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .mcu_req       (mcu_req),
    .mcu_page_addr (mcu_page_addr),
    .mcu_grant     (mcu_grant),
    .word_valid    (word_valid),
    .word          (word),
    .credit_ret    (credit_ret),
    .xfer_done     (xfer_done)
  );

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired, test %s never finished", cur_test);
    $display(">>> FAIL");
    $finish;
  end

  task automatic flag_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
    errors++;
  endtask

  task automatic flag_problem(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  // sink side, one credit back per consumed word after a random gap
  task automatic drive_credits();
    int gap_left;
    gap_left = 0;
    forever
    begin
      @(negedge CLK);
      if (gap_left > 0)
      begin
        credit_ret = 1'b0;
        gap_left--;
      end
      else if (outstanding > 0)
      begin
        credit_ret = 1'b1;
        gap_left   = $urandom_range(gap_max, 0);
      end
      else
        credit_ret = 1'b0;
    end
  endtask

  // MCU model, grant after a random delay, dropped with the request
  task automatic answer_grants();
    int grant_wait;
    grant_wait = 0;
    forever
    begin
      @(negedge CLK);
      if (mcu_req !== 1'b1)
      begin
        mcu_grant  = 1'b0;
        grant_wait = $urandom_range(grant_max, grant_min);
      end
      else if (!mcu_grant)
      begin
        if (grant_wait == 0)
          mcu_grant = 1'b1;
        else
          grant_wait--;
      end
    end
  endtask

  task automatic watch_outputs();
    forever
    begin
      @(posedge CLK);
      if (RST)
      begin
        if (word_valid)
          got_q.push_back(word);
        assert (!word_valid || (mcu_req && mcu_grant))
        else flag_problem("a word went out before the page was granted");
        outstanding = outstanding + int'(word_valid) - int'(credit_ret);
        assert (outstanding <= OUT_CREDITS)
        else flag_problem("more words outstanding than the stream has credits");
        if (xfer_done)
          done_count++;
        if (mcu_req && !mcu_grant)
          stall_cycles++;
        if (mcu_req && !mcu_req_q)
          got_page_q.push_back(mcu_page_addr);
        else if (mcu_req)
        begin
          assert (mcu_page_addr == page_q)
          else flag_problem("mcu_page_addr changed while mcu_req was high");
        end
        mcu_req_q = mcu_req;
        page_q    = mcu_page_addr;
      end
    end
  endtask

  // splits a request into blocks, at most BLOCK_LEN and never over a page end
  task automatic build_expected(input logic [ADDR_W-1:0] addr, input int len,
                                input logic [SECT_W-1:0] sect);
    logic [ADDR_W-1:0] a;
    int                left;
    int                cnt;
    int                room;
    dram_word_t        w;
    exp_q.delete();
    exp_blk_q.delete();
    exp_page_q.delete();
    a    = addr;
    left = len;
    while (left > 0)
    begin
      room = (1 << PAGE_BITS) - int'(a[PAGE_BITS-1:0]);
      cnt  = BLOCK_LEN;
      if (room < cnt)
        cnt = room;
      if (left < cnt)
        cnt = left;
      exp_blk_q.push_back(cnt);
      exp_page_q.push_back(a[ADDR_W-1:PAGE_BITS]);
      for (int i = 0; i < cnt; i++)
      begin
        w.addr          = a + i;
        w.section       = sect;
        w.last_of_block = (i == cnt - 1);
        w.last_of_xfer  = (i == cnt - 1) && (left == cnt);
        exp_q.push_back(w);
      end
      a    = a + cnt;
      left = left - cnt;
    end
  endtask

  task automatic compare_words();
    int got_blk_q[$];
    int run;
    assert (got_q.size() == exp_q.size())
    else flag_value("word count", exp_q.size(), got_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
    begin
      assert (got_q[i] == exp_q[i])
      else flag_value($sformatf("word %0d", i), exp_q[i], got_q[i]);
    end
    run = 0;
    foreach (got_q[i])
    begin
      run++;
      if (got_q[i].last_of_block)
      begin
        got_blk_q.push_back(run);
        run = 0;
      end
    end
    assert (got_blk_q.size() == exp_blk_q.size())
    else flag_value("block count", exp_blk_q.size(), got_blk_q.size());
    for (int i = 0; i < got_blk_q.size() && i < exp_blk_q.size(); i++)
    begin
      assert (got_blk_q[i] == exp_blk_q[i])
      else flag_value($sformatf("block %0d length", i), exp_blk_q[i], got_blk_q[i]);
    end
    assert (got_page_q.size() == exp_page_q.size())
    else flag_value("page requests", exp_page_q.size(), got_page_q.size());
    for (int i = 0; i < got_page_q.size() && i < exp_page_q.size(); i++)
    begin
      assert (got_page_q[i] == exp_page_q[i])
      else flag_value($sformatf("block %0d page", i), exp_page_q[i], got_page_q[i]);
    end
    assert (done_count == 1)
    else flag_value("xfer_done pulses", 1, done_count);
  endtask

  task automatic run_xfer(input logic [ADDR_W-1:0] addr, input int len,
                          input logic [SECT_W-1:0] sect);
    build_expected(addr, len, sect);
    got_q.delete();
    got_page_q.delete();
    done_count   = 0;
    stall_cycles = 0;
    @(negedge CLK);
    while (!req_ready)
      @(negedge CLK);
    req_valid   = 1'b1;
    req.addr    = addr;
    req.section = sect;
    req.length  = LEN_W'(len);
    @(negedge CLK);
    req_valid = 1'b0;
    while (done_count == 0)
      @(negedge CLK);
    while (outstanding != 0) // let the sink hand back every credit
      @(negedge CLK);
    repeat (3) @(negedge CLK);
    compare_words();
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_base = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_base)
      $display("test %s finished, ok", cur_test);
    else
    begin
      $display("test %s finished, %0d errors", cur_test, errors - err_base);
      tests_failed++;
    end
  endtask

  task automatic reset_state_check();
    begin_test("reset");
    assert (req_ready === 1'b1) else flag_value("req_ready", 1, req_ready);
    assert (mcu_req === 1'b0) else flag_value("mcu_req", 0, mcu_req);
    assert (word_valid === 1'b0) else flag_value("word_valid", 0, word_valid);
    assert (xfer_done === 1'b0) else flag_value("xfer_done", 0, xfer_done);
    end_test();
  endtask

  task automatic single_page_xfer();
    begin_test("single_page");
    run_xfer(32'h0000_0100, LEN_SHORT, 2'd2);
    end_test();
  endtask

  task automatic multi_block_xfer();
    begin_test("multi_block");
    run_xfer(32'h0001_0000, LEN_MULTI, 2'd1); // 24 24 24 24 4
    end_test();
  endtask

  task automatic page_cross_xfer();
    begin_test("page_cross");
    run_xfer(32'h0000_3FFB, LEN_CROSS, 2'd3); // five words left in page 3
    assert (got_q.size() >= 5 && got_q[4].last_of_block)
    else flag_problem("first block did not end at the page boundary");
    assert (got_page_q.size() >= 2 && got_page_q[0] != got_page_q[1])
    else flag_problem("page address did not change on the second block");
    end_test();
  endtask

  task automatic backpressure_xfer();
    begin_test("backpressure");
    gap_max = MAX_GAP;
    run_xfer(32'h0000_0FF0, LEN_BP, 2'd0);
    gap_max = 0;
    end_test();
  endtask

  task automatic delayed_grant_xfer();
    int min_stall;
    begin_test("delayed_grant");
    grant_min = SLOW_GRANT_MIN;
    grant_max = SLOW_GRANT_MAX;
    run_xfer(32'h0002_0010, LEN_SLOW, 2'd1);
    min_stall = SLOW_GRANT_MIN * exp_blk_q.size();
    assert (stall_cycles >= min_stall)
    else flag_value("stall cycles", min_stall, stall_cycles);
    grant_min = 0;
    grant_max = 2;
    end_test();
  endtask

  initial
  begin
    RST          = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    mcu_grant    = 1'b0;
    credit_ret   = 1'b0;
    cur_test     = "startup";
    errors       = 0;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    done_count   = 0;
    stall_cycles = 0;
    outstanding  = 0;
    gap_max      = 0;
    grant_min    = 0;
    grant_max    = 2;
    mcu_req_q    = 1'b0;
    page_q       = '0;
    void'($urandom(SEED));
    fork
      drive_credits();
      answer_grants();
      watch_outputs();
    join_none
    repeat (RESET_CYCLES) @(negedge CLK);
    RST = 1'b1;
    reset_state_check();
    single_page_xfer();
    multi_block_xfer();
    page_cross_xfer();
    backpressure_xfer();
    delayed_grant_xfer();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/lsab_pkg.sv
hw/xfer_sequencer.sv
hw/xfer_counter.sv
hw/block_mover.sv
hw/dram_xfer_engine.sv
verif/tb_dram_xfer_engine.sv

// File: Bender.yml
package:
  name: dram_xfer_engine

sources:
  - files:
      - hw/lsab_pkg.sv
      - hw/xfer_sequencer.sv
      - hw/xfer_counter.sv
      - hw/block_mover.sv
      - hw/dram_xfer_engine.sv
  - target: simulation
    files:
      - verif/tb_dram_xfer_engine.sv
